//--- source/uart_pkg.sv
// Register map, field positions, widths and FSM types shared by all UART modules
`default_nettype none

package uart_pkg;

  // Vector types
  typedef logic [7:0]  reg_addr_t;   // Low byte of the bus address
  typedef logic [31:0] reg_data_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] baud_div_t;   // Clocks per oversample tick

  localparam int FIFO_DEPTH = 16;
  typedef logic [$clog2(FIFO_DEPTH):0] fifo_level_t;

  // Oversampling
  localparam int OVERSAMPLE = 16;
  typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;
  localparam tick_cnt_t TICK_MID  = tick_cnt_t'(OVERSAMPLE / 2 - 1);  // Start bit centre
  localparam tick_cnt_t TICK_LAST = tick_cnt_t'(OVERSAMPLE - 1);      // Data/stop centre

  localparam baud_div_t DEFAULT_BAUD_DIV = 16'd27;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam reg_addr_t ADDR_DATA   = 8'h00;
  localparam reg_addr_t ADDR_STATUS = 8'h04;
  localparam reg_addr_t ADDR_CTRL   = 8'h08;
  localparam reg_addr_t ADDR_BAUD   = 8'h0C;
  localparam reg_addr_t ADDR_ISR    = 8'h10;
  localparam reg_addr_t ADDR_IMR    = 8'h14;
  localparam reg_addr_t ADDR_FCR    = 8'h18;

  localparam reg_data_t READ_DEFAULT = 32'hDEAD_BEEF;

  // Control bits
  localparam int CTRL_TX_EN    = 0;
  localparam int CTRL_RX_EN    = 1;
  localparam int CTRL_STOP2    = 4;
  localparam int CTRL_PAR_ODD  = 6;
  localparam int CTRL_PAR_EN   = 7;
  localparam int CTRL_LOOPBACK = 9;

  // Status bits
  localparam int ST_RX_AVAIL = 0;
  localparam int ST_TX_BUSY  = 4;
  localparam int ST_PAR_ERR  = 6;
  localparam int ST_STOP_ERR = 7;
  localparam int ST_RX_FULL  = 8;
  localparam int ST_TX_FULL  = 9;

  // Interrupt and flush bits
  localparam int ISR_RX_AVAIL = 0;
  localparam int ISR_TX_EMPTY = 1;
  localparam int FCR_TX_FLUSH = 0;
  localparam int FCR_RX_FLUSH = 1;

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP,
    RX_DONE
  } rx_state_t;

endpackage

`default_nettype wire

//--- source/uart_fifo.sv
// Byte FIFO with the head always visible, one instance per direction in the UART
`default_nettype none
`timescale 1ns/1ps

module uart_fifo (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            push,
  input  uart_pkg::byte_t wdata,
  input  logic            pop,
  output uart_pkg::byte_t rdata,
  output logic            full,
  output logic            empty
);
  import uart_pkg::*;

  byte_t                         mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  fifo_level_t                   level;
  logic                          do_push;
  logic                          do_pop;

  assign full    = (level == fifo_level_t'(FIFO_DEPTH));
  assign empty   = (level == '0);
  assign do_push = push && !full;    // Overflowing writes are lost
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];      // First word falls through

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointers wrap
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

endmodule

`default_nettype wire

//--- source/uart_baud_gen.sv
// Oversample tick generator, restarted by each engine at the start of a frame
`default_nettype none
`timescale 1ns/1ps

module uart_baud_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  input  uart_pkg::baud_div_t baud_div,
  output logic                tick
);
  import uart_pkg::*;

  baud_div_t cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (!run || baud_div == '0) begin
      // Held in phase until the engine starts, zero divisor stalls
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == baud_div - 1'b1) begin
      cnt  <= '0;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// Transmit engine, pulls bytes from the TX FIFO and serialises them onto txd
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tx_en,
  input  logic            par_en,
  input  logic            par_odd,
  input  logic            stop2,
  input  logic            fifo_empty,
  input  uart_pkg::byte_t fifo_data,
  output logic            fifo_pop,
  input  logic            tick,
  output logic            run,
  output logic            txd,
  output logic            busy
);
  import uart_pkg::*;

  tx_state_t   state;
  tick_cnt_t   tick_cnt;
  logic [3:0]  bits_left;   // Bit periods left in the frame, current one included
  logic [10:0] shift;
  logic        parity;
  logic        bit_end;

  assign parity  = ^fifo_data ^ par_odd;
  assign bit_end = tick && (tick_cnt == TICK_LAST);
  assign run     = (state == TX_SEND);
  assign busy    = (state != TX_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= TX_IDLE;
      tick_cnt  <= '0;
      bits_left <= '0;
      shift     <= '1;
      txd       <= 1'b1;
      fifo_pop  <= 1'b0;
    end else begin
      fifo_pop <= 1'b0;
      case (state)
        TX_IDLE: begin
          txd      <= 1'b1;
          tick_cnt <= '0;
          if (tx_en && !fifo_empty) begin
            state     <= TX_SEND;
            fifo_pop  <= 1'b1;
            txd       <= 1'b0;                                   // Start bit
            bits_left <= 4'd10 + {3'b000, par_en} + {3'b000, stop2};
            if (par_en) shift <= {2'b11, parity, fifo_data};
            else shift <= {3'b111, fifo_data};
          end
        end

        TX_SEND: begin
          if (tick) tick_cnt <= tick_cnt + 1'b1;  // Wraps to 0 after TICK_LAST
          if (bit_end) begin
            if (bits_left == 4'd1) begin
              // Last stop bit has run its full period
              state <= TX_IDLE;
              txd   <= 1'b1;
            end else begin
              txd       <= shift[0];
              shift     <= {1'b1, shift[10:1]};
              bits_left <= bits_left - 1'b1;
            end
          end
        end

        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
// Receive engine, oversamples the serial line and pushes each frame's byte into the RX FIFO
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx_en,
  input  logic            par_en,
  input  logic            par_odd,
  input  logic            stop2,
  input  logic            rxd,
  input  logic            tick,
  output logic            run,
  output logic            push,
  output uart_pkg::byte_t data,
  output logic            par_err,
  output logic            stop_err
);
  import uart_pkg::*;

  rx_state_t  state;
  tick_cnt_t  tick_cnt;
  logic [2:0] bit_cnt;
  logic [2:0] rx_sync;      // Two sync stages plus one for edge detection
  logic       line;
  logic       line_prev;
  logic       sample;
  logic       second_stop;
  logic       stop_bad;
  logic       par_bit;
  byte_t      shifter;

  assign line      = rx_sync[1];
  assign line_prev = rx_sync[2];
  assign run       = (state != RX_IDLE);
  assign push      = (state == RX_DONE);
  assign data      = shifter;

  // Centre of the start bit, or of every later bit
  assign sample = tick && (tick_cnt == ((state == RX_START) ? TICK_MID : TICK_LAST));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rx_sync <= 3'b111;  // Line idles high
    else rx_sync <= {rx_sync[1:0], rxd};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) tick_cnt <= '0;
    else if (state == RX_IDLE || sample) tick_cnt <= '0;
    else if (tick) tick_cnt <= tick_cnt + 1'b1;
  end

  // ----------------------------------------------------------
  // Frame FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      second_stop <= 1'b0;
      stop_bad    <= 1'b0;
      par_err     <= 1'b0;
      stop_err    <= 1'b0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (rx_en && line_prev && !line) state <= RX_START;  // Falling edge
        end

        RX_START: begin
          if (sample) begin
            bit_cnt     <= '0;
            second_stop <= 1'b0;
            state       <= line ? RX_IDLE : RX_DATA;  // High at centre is a glitch
          end
        end

        RX_DATA: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= par_en ? RX_PARITY : RX_STOP;
          end
        end

        RX_PARITY: begin
          if (sample) state <= RX_STOP;
        end

        RX_STOP: begin
          if (sample) begin
            if (!line) begin
              stop_bad <= 1'b1;        // Frame ends at the bad stop bit
              state    <= RX_DONE;
            end else if (stop2 && !second_stop) begin
              second_stop <= 1'b1;
            end else begin
              stop_bad <= 1'b0;
              state    <= RX_DONE;
            end
          end
        end

        RX_DONE: begin
          // Byte is pushed this cycle, flags follow with it
          par_err  <= par_en && (par_bit != (^shifter ^ par_odd));
          stop_err <= stop_bad;
          state    <= RX_IDLE;
        end

        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample && state == RX_DATA) shifter <= {line, shifter[7:1]};  // LSB first
    if (sample && state == RX_PARITY) par_bit <= line;
  end

endmodule

`default_nettype wire

//--- source/uart_regs.sv
// Register block of the UART, decodes CPU accesses and raises the interrupt
`default_nettype none
`timescale 1ns/1ps

module uart_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::reg_addr_t reg_addr,
  input  uart_pkg::reg_data_t reg_wdata,
  input  logic                reg_we,
  input  logic                reg_re,
  output uart_pkg::reg_data_t reg_rdata,
  output logic                tx_push,
  output uart_pkg::byte_t     tx_data,
  input  logic                tx_full,
  input  logic                tx_empty,
  output logic                tx_flush,
  output logic                rx_pop,
  input  uart_pkg::byte_t     rx_data,
  input  logic                rx_full,
  input  logic                rx_empty,
  output logic                rx_flush,
  input  logic                tx_busy,
  input  logic                par_err,
  input  logic                stop_err,
  output logic                tx_en,
  output logic                rx_en,
  output logic                par_en,
  output logic                par_odd,
  output logic                stop2,
  output logic                loopback,
  output uart_pkg::baud_div_t baud_div,
  output logic                intr
);
  import uart_pkg::*;

  reg_data_t  ctrl;
  reg_data_t  imr;
  reg_data_t  status;
  logic [1:0] isr;

  assign tx_en    = ctrl[CTRL_TX_EN];
  assign rx_en    = ctrl[CTRL_RX_EN];
  assign stop2    = ctrl[CTRL_STOP2];
  assign par_odd  = ctrl[CTRL_PAR_ODD];
  assign par_en   = ctrl[CTRL_PAR_EN];
  assign loopback = ctrl[CTRL_LOOPBACK];

  assign intr = |(isr & imr[1:0]);

  // ----------------------------------------------------------
  // Writes, strobes and interrupt status
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl     <= '0;
      baud_div <= DEFAULT_BAUD_DIV;
      imr      <= '0;
      isr      <= '0;
      tx_push  <= 1'b0;
      rx_pop   <= 1'b0;
      tx_flush <= 1'b0;
      rx_flush <= 1'b0;
    end else begin
      tx_push  <= reg_we && (reg_addr == ADDR_DATA);
      rx_pop   <= reg_re && (reg_addr == ADDR_DATA);  // Pop the head just read
      tx_flush <= reg_we && (reg_addr == ADDR_FCR) && reg_wdata[FCR_TX_FLUSH];
      rx_flush <= reg_we && (reg_addr == ADDR_FCR) && reg_wdata[FCR_RX_FLUSH];
      if (reg_we) begin
        case (reg_addr)
          ADDR_CTRL: ctrl <= reg_wdata;
          ADDR_BAUD: baud_div <= baud_div_t'(reg_wdata);
          ADDR_ISR:  isr <= isr & ~reg_wdata[1:0];      // Write 1 to clear
          ADDR_IMR:  imr <= reg_wdata;
          default:   ;
        endcase
      end
      // Live conditions win over a clear in the same cycle
      if (!rx_empty) isr[ISR_RX_AVAIL] <= 1'b1;
      if (tx_empty) isr[ISR_TX_EMPTY] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_we && reg_addr == ADDR_DATA) tx_data <= reg_wdata[7:0];
  end

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  always_comb begin
    status              = '0;
    status[ST_RX_AVAIL] = !rx_empty;
    status[ST_TX_BUSY]  = tx_busy;
    status[ST_PAR_ERR]  = par_err;
    status[ST_STOP_ERR] = stop_err;
    status[ST_RX_FULL]  = rx_full;
    status[ST_TX_FULL]  = tx_full;
  end

  always_comb begin
    case (reg_addr)
      ADDR_DATA:   reg_rdata = reg_data_t'(rx_data);
      ADDR_STATUS: reg_rdata = status;
      ADDR_CTRL:   reg_rdata = ctrl;
      ADDR_BAUD:   reg_rdata = reg_data_t'(baud_div);
      ADDR_ISR:    reg_rdata = reg_data_t'(isr);
      ADDR_IMR:    reg_rdata = imr;
      ADDR_FCR:    reg_rdata = reg_data_t'({rx_flush, tx_flush});
      default:     reg_rdata = READ_DEFAULT;
    endcase
  end

endmodule

`default_nettype wire

//--- source/uart_top.sv
// UART top level, connects the register block, FIFOs, baud generators and engines
`default_nettype none
`timescale 1ns/1ps

module uart_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                uart_rxd,
  output logic                uart_txd,
  input  uart_pkg::reg_data_t reg_addr,
  input  uart_pkg::reg_data_t reg_wdata,
  output uart_pkg::reg_data_t reg_rdata,
  input  logic                reg_we,
  input  logic                reg_re,
  output logic                intr
);
  import uart_pkg::*;

  // TX path
  logic      tx_push, tx_pop, tx_full, tx_empty, tx_flush;
  byte_t     tx_data, tx_head;
  logic      tx_run, tx_tick, tx_busy;
  // RX path
  logic      rx_push, rx_pop, rx_full, rx_empty, rx_flush;
  byte_t     rx_byte, rx_head;
  logic      rx_run, rx_tick, rx_line;
  logic      par_err, stop_err;
  // Control
  logic      tx_en, rx_en, par_en, par_odd, stop2, loopback;
  baud_div_t baud_div;

  assign rx_line = loopback ? uart_txd : uart_rxd;  // Internal loopback

  uart_regs regs (
    .clk      (clk),       .rst_n    (rst_n),
    .reg_addr (reg_addr[7:0]),
    .reg_wdata(reg_wdata), .reg_we   (reg_we),    .reg_re  (reg_re),
    .reg_rdata(reg_rdata),
    .tx_push  (tx_push),   .tx_data  (tx_data),   .tx_full (tx_full),
    .tx_empty (tx_empty),  .tx_flush (tx_flush),
    .rx_pop   (rx_pop),    .rx_data  (rx_head),   .rx_full (rx_full),
    .rx_empty (rx_empty),  .rx_flush (rx_flush),
    .tx_busy  (tx_busy),   .par_err  (par_err),   .stop_err(stop_err),
    .tx_en    (tx_en),     .rx_en    (rx_en),     .par_en  (par_en),
    .par_odd  (par_odd),   .stop2    (stop2),     .loopback(loopback),
    .baud_div (baud_div),  .intr     (intr)
  );

  // ----------------------------------------------------------
  // Transmit side
  // ----------------------------------------------------------
  uart_fifo tx_fifo (
    .clk  (clk),     .rst_n(rst_n),   .flush(tx_flush),
    .push (tx_push), .wdata(tx_data), .pop  (tx_pop),
    .rdata(tx_head), .full (tx_full), .empty(tx_empty)
  );

  uart_baud_gen tx_baud (
    .clk(clk), .rst_n(rst_n), .run(tx_run), .baud_div(baud_div), .tick(tx_tick)
  );

  uart_tx tx (
    .clk       (clk),      .rst_n    (rst_n),    .tx_en  (tx_en),
    .par_en    (par_en),   .par_odd  (par_odd),  .stop2  (stop2),
    .fifo_empty(tx_empty), .fifo_data(tx_head),  .fifo_pop(tx_pop),
    .tick      (tx_tick),  .run      (tx_run),   .txd    (uart_txd),
    .busy      (tx_busy)
  );

  // ----------------------------------------------------------
  // Receive side
  // ----------------------------------------------------------
  uart_baud_gen rx_baud (
    .clk(clk), .rst_n(rst_n), .run(rx_run), .baud_div(baud_div), .tick(rx_tick)
  );

  uart_rx rx (
    .clk    (clk),     .rst_n  (rst_n),   .rx_en   (rx_en),
    .par_en (par_en),  .par_odd(par_odd), .stop2   (stop2),
    .rxd    (rx_line), .tick   (rx_tick), .run     (rx_run),
    .push   (rx_push), .data   (rx_byte), .par_err (par_err),
    .stop_err(stop_err)
  );

  uart_fifo rx_fifo (
    .clk  (clk),     .rst_n(rst_n),   .flush(rx_flush),
    .push (rx_push), .wdata(rx_byte), .pop  (rx_pop),
    .rdata(rx_head), .full (rx_full), .empty(rx_empty)
  );

endmodule

`default_nettype wire

//--- sim/tb_uart.sv
// Self-checking testbench for uart_top, runs the frames of the pattern file through the UART
`default_nettype none
`timescale 1ns/1ps

module tb_uart;
  import uart_pkg::*;

  localparam int NUM_PATTERNS = 11;
  localparam int BAUD_DIV     = 2;
  localparam int BIT_CLKS     = OVERSAMPLE * BAUD_DIV;
  localparam int POLL_LIMIT   = 20 * BIT_CLKS;   // Well beyond one frame
  localparam int WATCHDOG_NS  = NUM_PATTERNS * 13 * 16 * BAUD_DIV * 10 * 3;

  logic      clk;
  logic      rst_n;
  logic      uart_rxd;
  logic      uart_txd;
  reg_data_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_we;
  logic      reg_re;
  logic      intr;

  logic [15:0] pattern_mem [0:NUM_PATTERNS*3-1];  // ctrl, byte, error code per frame
  logic [31:0] rng_state;

  uart_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .uart_rxd (uart_rxd),
    .uart_txd (uart_txd),
    .reg_addr (reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .reg_we   (reg_we),
    .reg_re   (reg_re),
    .intr     (intr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests finished");
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bit 0 is the start bit, the unused top bits idle high like stop bits
  function automatic logic [11:0] frame_bits(input byte_t data, input logic par_en,
                                             input logic par_odd);
    if (par_en) return {2'b11, (^data) ^ par_odd, data, 1'b0};
    else return {3'b111, data, 1'b0};
  endfunction

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_addr  = reg_data_t'(addr);
    reg_wdata = data;
    reg_we    = 1'b1;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk);
    reg_addr = reg_data_t'(addr);
    reg_re   = 1'b1;
    #2;
    data = reg_rdata;   // Read data is combinational from the address
    @(negedge clk);
    reg_re   = 1'b0;
  endtask

  task automatic wait_status(input int bit_pos, input logic value, input string what);
    reg_data_t st;
    int        polls;
    polls = 0;
    read_reg(ADDR_STATUS, st);
    while (st[bit_pos] !== value && polls < POLL_LIMIT) begin
      read_reg(ADDR_STATUS, st);
      polls++;
    end
    if (st[bit_pos] !== value) fail_run({"timeout while waiting for ", what});
  endtask

  task automatic wait_start_bit();
    int polls;
    polls = 0;
    @(negedge clk);
    while (uart_txd !== 1'b0 && polls < POLL_LIMIT) begin
      @(negedge clk);
      polls++;
    end
    if (uart_txd !== 1'b0) fail_run("no start bit appeared on uart_txd");
  endtask

  task automatic wait_intr();
    int polls;
    polls = 0;
    while (intr !== 1'b1 && polls < POLL_LIMIT) begin
      @(negedge clk);
      polls++;
    end
    if (intr !== 1'b1) fail_run("intr never rose after the byte was sent");
  endtask

  // ----------------------------------------------------------
  // Serial line checks
  // ----------------------------------------------------------
  task automatic check_tx_frame(input byte_t data, input reg_data_t ctrl);
    logic [11:0] bits;
    int          nbits;
    bits  = frame_bits(data, ctrl[CTRL_PAR_EN], ctrl[CTRL_PAR_ODD]);
    nbits = 10 + int'(ctrl[CTRL_PAR_EN]) + int'(ctrl[CTRL_STOP2]);
    reg_addr = reg_data_t'(ADDR_STATUS);  // Busy flag watched through the frame
    wait_start_bit();
    repeat (BIT_CLKS / 2) @(negedge clk);
    for (int b = 0; b < nbits; b++) begin
      #1;
      check_value($sformatf("uart_txd bit %0d", b), 32'(bits[b]), 32'(uart_txd));
      check_value("status.tx_busy", 32'd1, 32'(reg_rdata[ST_TX_BUSY]));
      if (b < nbits - 1) repeat (BIT_CLKS) @(negedge clk);
    end
    wait_status(ST_TX_BUSY, 1'b0, "tx_busy to fall");
    check_value("uart_txd", 32'd1, 32'(uart_txd));
  endtask

  task automatic drive_rx_frame(input byte_t data, input reg_data_t ctrl, input int err_code);
    logic [11:0] bits;
    int          nbits;
    bits  = frame_bits(data, ctrl[CTRL_PAR_EN], ctrl[CTRL_PAR_ODD]);
    nbits = 10 + int'(ctrl[CTRL_PAR_EN]) + int'(ctrl[CTRL_STOP2]);
    if (err_code == 1) bits[9] = ~bits[9];                           // Wrong parity
    if (err_code == 2) bits[9 + int'(ctrl[CTRL_PAR_EN])] = 1'b0;     // Low first stop
    @(negedge clk);
    for (int b = 0; b < nbits; b++) begin
      uart_rxd = bits[b];
      repeat (BIT_CLKS) @(negedge clk);
    end
    uart_rxd = 1'b1;
    repeat (BIT_CLKS) @(negedge clk);   // One idle bit
  endtask

  task automatic check_rx_result(input byte_t data, input logic exp_par, input logic exp_stop);
    reg_data_t rd;
    wait_status(ST_RX_AVAIL, 1'b1, "a received byte");
    read_reg(ADDR_STATUS, rd);
    check_value("status.par_err", 32'(exp_par), 32'(rd[ST_PAR_ERR]));
    check_value("status.stop_err", 32'(exp_stop), 32'(rd[ST_STOP_ERR]));
    read_reg(ADDR_DATA, rd);
    check_value("rx data", 32'(data), rd);
    read_reg(ADDR_STATUS, rd);
    check_value("status.rx_avail", 32'd0, 32'(rd[ST_RX_AVAIL]));
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    reg_data_t rd;
    reg_data_t ctrl;
    byte_t     data;
    int        code;
    int        gap;
    rst_n     = 1'b0;
    uart_rxd  = 1'b1;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    rng_state = 32'd54;
    pattern_mem[NUM_PATTERNS*3-1] = '1;  // Replaced by the last error code on a full load
    $readmemh("sim/uart_patterns.hex", pattern_mem);
    if (pattern_mem[NUM_PATTERNS*3-1] > 16'd2)
      fail_run("pattern file sim/uart_patterns.hex could not be read");
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset values and read back
    read_reg(ADDR_CTRL, rd);
    check_value("ctrl", 32'd0, rd);
    read_reg(ADDR_BAUD, rd);
    check_value("baud", 32'd27, rd);
    check_value("intr", 32'd0, 32'(intr));
    write_reg(ADDR_CTRL, 32'h0000_0250);
    read_reg(ADDR_CTRL, rd);
    check_value("ctrl", 32'h0000_0250, rd);
    write_reg(ADDR_IMR, 32'hA5A5_0000);  // No interrupt source enabled
    read_reg(ADDR_IMR, rd);
    check_value("imr", 32'hA5A5_0000, rd);
    check_value("intr", 32'd0, 32'(intr));
    write_reg(ADDR_IMR, 32'd0);
    write_reg(ADDR_BAUD, BAUD_DIV);
    read_reg(ADDR_BAUD, rd);
    check_value("baud", 32'(BAUD_DIV), rd);
    read_reg(8'h1C, rd);
    check_value("unmapped read", 32'hDEAD_BEEF, rd);
    read_reg(8'h80, rd);
    check_value("unmapped read", 32'hDEAD_BEEF, rd);

    for (int p = 0; p < NUM_PATTERNS; p++) begin
      ctrl = reg_data_t'(pattern_mem[3*p]);
      data = byte_t'(pattern_mem[3*p+1]);
      code = int'(pattern_mem[3*p+2]);
      write_reg(ADDR_CTRL, ctrl);
      if (code == 0) begin
        write_reg(ADDR_DATA, reg_data_t'(data));
        check_tx_frame(data, ctrl);
        check_rx_result(data, 1'b0, 1'b0);   // Came back through loopback
      end else begin
        drive_rx_frame(data, ctrl, code);
        check_rx_result(data, code == 1, code == 2);
        drive_rx_frame(data, ctrl, 0);
        check_rx_result(data, 1'b0, 1'b0);   // Clean frame clears both flags
      end
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state % 32'd24) + 2;
      repeat (gap) @(negedge clk);
    end

    // Interrupt on receive, flush and clear
    write_reg(ADDR_CTRL, 32'h0000_0203);
    write_reg(ADDR_ISR, 32'h3);
    write_reg(ADDR_IMR, 32'h1);
    read_reg(ADDR_ISR, rd);
    check_value("isr.rx_avail", 32'd0, 32'(rd[ISR_RX_AVAIL]));
    check_value("intr", 32'd0, 32'(intr));
    write_reg(ADDR_DATA, 32'h0000_005C);
    wait_intr();
    read_reg(ADDR_STATUS, rd);
    check_value("status.rx_avail", 32'd1, 32'(rd[ST_RX_AVAIL]));
    write_reg(ADDR_ISR, 32'h1);          // Byte still queued, bit stays set
    read_reg(ADDR_ISR, rd);
    check_value("isr.rx_avail", 32'd1, 32'(rd[ISR_RX_AVAIL]));
    check_value("intr", 32'd1, 32'(intr));
    write_reg(ADDR_FCR, 32'h2);
    read_reg(ADDR_STATUS, rd);
    check_value("status.rx_avail", 32'd0, 32'(rd[ST_RX_AVAIL]));
    write_reg(ADDR_ISR, 32'h1);
    read_reg(ADDR_ISR, rd);
    check_value("isr.rx_avail", 32'd0, 32'(rd[ISR_RX_AVAIL]));
    check_value("intr", 32'd0, 32'(intr));

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_top.sv
sim/tb_uart.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module tb_uart -f compile.f \
  && ./obj_dir/Vtb_uart \
  || exit 1

//--- sim/uart_patterns.hex
// ctrl value   data byte   error injection (0 none, 1 bad parity, 2 bad stop)
// Lines with an error code drive uart_rxd from the testbench with loopback off
0203 a5 0
0283 3c 0
02c3 7e 0
0213 01 0
0293 80 0
02d3 ff 0
0203 00 0
0082 5a 1
00c2 c3 1
0002 96 2
0092 69 2
